// ==== verilog.f ====
+incdir+common
common/dac_pkg.sv
hdl/dac_frame_fifo.sv
spi/dac_spi_shifter.sv
dac_regs/dac_reg_map.sv
hdl/dac_ad5601_top.sv
verification/dac_ad5601_properties.sv
verification/tb_dac_ad5601.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the AD5601 controller testbench with Verilator and runs it.
# Exits non-zero when the build fails, the run fails or the log reports failure.

set -u
cd "$(dirname "$0")"

TOP=tb_dac_ad5601
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f verilog.f -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build error"
    exit 1
fi

"./obj_dir/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    echo "testbench reported errors, see $LOG"
    exit 1
fi

echo "run finished, see $LOG"
exit 0

// ==== verification/tb_dac_ad5601.sv ====
// testbench for the AD5601 controller, table of bus and strobe operations
// captures SPI frames on falling SCLK and checks them against a register model
`timescale 1ns/1ps
`include "dac_consts.svh"

module tb_dac_ad5601
    import dac_pkg::*;
();

    localparam int FRAME_CYC = 16 * 2 * `DAC_SCLK_DIV + 2;

    typedef enum {OP_EN, OP_RD, OP_WR, OP_STB, OP_FRAME, OP_QUIET, OP_INIT, OP_BURST, OP_SETTLE} op_t;

    typedef struct {
        op_t         op;
        logic [3:0]  addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic [1:0]  resp;
    } entry_t;

    logic        clk_ifc;
    logic        set_default_on_reset;
    logic        en_avmm_ctrl;
    logic [3:0]  address;
    logic        write;
    logic [31:0] writedata;
    logic        read;
    logic [31:0] readdata;
    logic        readdatavalid;
    logic        writeresponsevalid;
    logic [1:0]  response;
    logic [7:0]  dac_data_in;
    logic        dac_data_in_valid_stb;
    logic        dac_data_in_updated_stb;
    logic        initdone;
    logic        spi_sclk;
    logic        spi_ssn;
    logic        spi_mosi;

    entry_t      tbl[$];
    logic [15:0] cap_q[$];      // captured spi frames
    logic [15:0] burst_q[$];    // values written back to back
    logic [15:0] shift_in;
    integer      seed = 32'hc1189416;
    int          bit_cnt;
    int          frames_seen;
    int          upd_count;
    int          errors;
    int          checks;
    int          errs_before;
    int          cycles;
    int          limit;

    dac_ad5601_top uut (.*);

    initial begin
        clk_ifc = 1'b0;
        forever #10 clk_ifc = ~clk_ifc;
    end

    ////////////////////////////////////////
    // spi capture

    always @(negedge spi_sclk) begin
        if (spi_ssn === 1'b0) begin
            shift_in = {shift_in[14:0], spi_mosi};  // msb first
            bit_cnt++;
        end
    end

    always @(posedge spi_ssn) begin
        if (bit_cnt == 16) begin
            cap_q.push_back(shift_in);
            frames_seen++;
        end else if (bit_cnt != 0) begin
            $display("FAILED at %0d ns: spi frame with %0d bits", $time, bit_cnt);
            errors++;
        end
        bit_cnt = 0;
    end

    always @(negedge clk_ifc) begin
        if (dac_data_in_updated_stb === 1'b1) upd_count++;
    end

    initial begin : watchdog
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk_ifc);
            cycles++;
        end
        $display("timeout: run stopped after %0d clock cycles", cycles);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////
    // helpers

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    function automatic void add_entry(op_t op, logic [3:0] addr, logic [31:0] data,
                                      logic [31:0] exp, logic [1:0] resp);
        entry_t e;
        e.op   = op;
        e.addr = addr;
        e.data = data;
        e.exp  = exp;
        e.resp = resp;
        tbl.push_back(e);
    endfunction

    task automatic tick();
        @(posedge clk_ifc);
        #2;     // drive just after the edge
    endtask

    function automatic bit last_matches();
        return (cap_q.size() != 0) && (cap_q[$] == burst_q[$]);
    endfunction

    task automatic check_subsequence();
        int j;
        bit found;
        j = 0;
        foreach (cap_q[k]) begin
            found = 1'b0;
            while (j < burst_q.size() && !found) begin
                if (burst_q[j] == cap_q[k]) found = 1'b1;
                j++;
            end
            check(32'(found), 32'd1, "captured frame is an in-order written value");
        end
        check(32'(cap_q[$]), 32'(burst_q[$]), "last frame equals last write");
    endtask

    ////////////////////////////////////////
    // stimulus table with register model

    task automatic build_table();
        logic [31:0] dac_model;
        logic [31:0] wval;
        logic [7:0]  code;
        dac_model = 32'(`DAC_DEFAULT);
        // default frame after reset
        add_entry(OP_FRAME, 4'd0, 32'd0, 32'(`DAC_DEFAULT), DAC_RESP_OKAY);
        add_entry(OP_INIT, 4'd0, 32'd0, 32'd1, DAC_RESP_OKAY);
        // plain reads and decode errors
        add_entry(OP_RD, 4'(`DAC_ADDR_VERSION), 32'd0, `DAC_VERSION_ID, DAC_RESP_OKAY);
        add_entry(OP_RD, 4'(`DAC_ADDR_STATE), 32'd0, 32'd1, DAC_RESP_OKAY);
        add_entry(OP_RD, 4'(`DAC_ADDR_EN_CTRL), 32'd0, 32'd0, DAC_RESP_OKAY);
        add_entry(OP_RD, 4'd5, 32'd0, 32'd0, DAC_RESP_SLVERR);
        add_entry(OP_WR, 4'd4, 32'h0000_1234, 32'd0, DAC_RESP_SLVERR);
        // bus control of the dac
        add_entry(OP_EN, 4'd0, 32'd1, 32'd0, DAC_RESP_OKAY);
        add_entry(OP_RD, 4'(`DAC_ADDR_EN_CTRL), 32'd0, 32'd1, DAC_RESP_OKAY);
        wval = 32'h0bad_5a3c;
        dac_model = wval;
        add_entry(OP_WR, 4'(`DAC_ADDR_DAC_REG), wval, 32'd0, DAC_RESP_OKAY);
        add_entry(OP_FRAME, 4'd0, 32'd0, 32'(wval[15:0]), DAC_RESP_OKAY);
        add_entry(OP_RD, 4'(`DAC_ADDR_DAC_REG), 32'd0, dac_model, DAC_RESP_OKAY);
        // strobe control, bus writes to the dac ignored
        add_entry(OP_EN, 4'd0, 32'd0, 32'd0, DAC_RESP_OKAY);
        add_entry(OP_WR, 4'(`DAC_ADDR_DAC_REG), 32'h0000_ffff, 32'd0, DAC_RESP_OKAY);
        add_entry(OP_QUIET, 4'd0, 32'(2 * FRAME_CYC), 32'd0, DAC_RESP_OKAY);
        add_entry(OP_RD, 4'(`DAC_ADDR_DAC_REG), 32'd0, dac_model, DAC_RESP_OKAY);
        for (int i = 0; i < 3; i++) begin
            code = 8'($random(seed));
            dac_model[13:6] = code;     // strobe only touches the code field
            add_entry(OP_STB, 4'd0, 32'(code), 32'd0, DAC_RESP_OKAY);
            add_entry(OP_FRAME, 4'd0, 32'd0, 32'(dac_model[15:0]), DAC_RESP_OKAY);
        end
        add_entry(OP_RD, 4'(`DAC_ADDR_DAC_REG), 32'd0, dac_model, DAC_RESP_OKAY);
        // back to back writes outrun the shifter
        add_entry(OP_EN, 4'd0, 32'd1, 32'd0, DAC_RESP_OKAY);
        for (int i = 0; i < 5; i++) begin
            wval = $random(seed);
            wval[15:12] = 4'(i + 1);    // keeps the frames distinct
            dac_model = wval;
            add_entry(OP_BURST, 4'(`DAC_ADDR_DAC_REG), wval, 32'd0, DAC_RESP_OKAY);
        end
        add_entry(OP_SETTLE, 4'd0, 32'd0, 32'd0, DAC_RESP_OKAY);
        add_entry(OP_RD, 4'(`DAC_ADDR_DAC_REG), 32'd0, dac_model, DAC_RESP_OKAY);
    endtask

    ////////////////////////////////////////
    // table entry execution

    task automatic run_entry(input entry_t e);
        int n;
        case (e.op)
            OP_EN: begin
                en_avmm_ctrl = e.data[0];
                tick();
                tick();     // registered copy inside the dut
            end
            OP_RD: begin
                address = e.addr;
                read    = 1'b1;
                tick();
                read    = 1'b0;
                check(32'(readdatavalid), 32'd1, "readdatavalid one cycle after read");
                check(32'(response), 32'(e.resp), "read response");
                if (e.resp == DAC_RESP_OKAY) check(readdata, e.exp, "read data");
            end
            OP_WR, OP_BURST: begin
                address   = e.addr;
                writedata = e.data;
                write     = 1'b1;
                tick();
                write     = 1'b0;
                check(32'(writeresponsevalid), 32'd1, "write response one cycle after write");
                check(32'(response), 32'(e.resp), "write response");
                if (e.op == OP_BURST) burst_q.push_back(e.data[15:0]);
            end
            OP_STB: begin
                dac_data_in           = e.data[7:0];
                dac_data_in_valid_stb = 1'b1;
                tick();
                dac_data_in_valid_stb = 1'b0;
            end
            OP_FRAME: begin
                n = 0;
                while (cap_q.size() == 0 && n < 4 * FRAME_CYC) begin
                    tick();
                    n++;
                end
                if (cap_q.size() == 0) begin
                    $display("no spi frame arrived within %0d cycles", n);
                    errors++;
                end else begin
                    tick();
                    tick();     // let the update strobe be counted
                    check(32'(cap_q.pop_front()), e.exp, "spi frame");
                    check(upd_count, frames_seen, "update strobes per frame");
                end
            end
            OP_QUIET: begin
                repeat (e.data) tick();
                check(cap_q.size(), 32'd0, "spi frames while none expected");
            end
            OP_INIT: check(32'(initdone), e.exp, "initdone");
            OP_SETTLE: begin
                n = 0;
                while (!last_matches() && n < 8 * FRAME_CYC) begin
                    tick();
                    n++;
                end
                repeat (2 * FRAME_CYC) tick();      // nothing may follow the last write
                if (cap_q.size() == 0) begin
                    $display("no spi frame arrived after the write burst");
                    errors++;
                end else begin
                    check_subsequence();
                end
                check(upd_count, frames_seen, "update strobes per frame");
                cap_q.delete();
                burst_q.delete();
            end
            default: ;
        endcase
    endtask

    initial begin
        set_default_on_reset  = 1'b1;
        en_avmm_ctrl          = 1'b0;
        address               = '0;
        write                 = 1'b0;
        writedata             = '0;
        read                  = 1'b0;
        dac_data_in           = '0;
        dac_data_in_valid_stb = 1'b0;
        build_table();
        limit = 200 * tbl.size() + 2000;
        repeat (3) @(posedge clk_ifc);
        #2;
        set_default_on_reset = 1'b0;

        foreach (tbl[i]) begin
            errs_before = errors;
            run_entry(tbl[i]);
            $display("test %0d %s %s", i, tbl[i].op.name(),
                     (errors == errs_before) ? "ok" : "error");
        end

        $display("%0d tests, %0d checks, %0d errors", tbl.size(), checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verification/dac_ad5601_properties.sv ====
// concurrent assertions on the AD5601 controller ports
// bound into every instance of the top level
`timescale 1ns/1ps

module dac_ad5601_properties (
    input logic clk_ifc,
    input logic set_default_on_reset,
    input logic read,
    input logic readdatavalid,
    input logic initdone,
    input logic spi_sclk,
    input logic spi_ssn
);

    ////////////////////////////////////////
    // spi idle state

    sclk_idle_high: assert property (@(posedge clk_ifc) disable iff (set_default_on_reset)
        spi_ssn |-> spi_sclk)
        else $error("spi_sclk low while spi_ssn is high");

    ////////////////////////////////////////
    // bus and status

    read_gets_valid: assert property (@(posedge clk_ifc) disable iff (set_default_on_reset)
        read |=> readdatavalid)
        else $error("readdatavalid missing one cycle after read");

    // sticky once the default frame is out
    initdone_sticky: assert property (@(posedge clk_ifc) disable iff (set_default_on_reset)
        !$fell(initdone))
        else $error("initdone fell outside reset");

endmodule

bind dac_ad5601_top dac_ad5601_properties u_props (
    .clk_ifc              (clk_ifc),
    .set_default_on_reset (set_default_on_reset),
    .read                 (read),
    .readdatavalid        (readdatavalid),
    .initdone             (initdone),
    .spi_sclk             (spi_sclk),
    .spi_ssn              (spi_ssn)
);

// ==== hdl/dac_ad5601_top.sv ====
// AD5601 nanoDAC controller top level
// bus register map feeds a frame queue that drains into the SPI shifter
`timescale 1ns/1ps
`include "dac_consts.svh"

module dac_ad5601_top
    import dac_pkg::*;
(
    input  logic                          clk_ifc,
    input  logic                          set_default_on_reset,
    input  logic                          en_avmm_ctrl,

    // host bus, single-word accesses
    input  logic [`DAC_ADDR_W-1:0]        address,
    input  logic                          write,
    input  logic [`DAC_DATA_W-1:0]        writedata,
    input  logic                          read,
    output logic [`DAC_DATA_W-1:0]        readdata,
    output logic                          readdatavalid,
    output logic                          writeresponsevalid,
    output logic [$bits(dac_resp_t)-1:0]  response,

    // local gain path, used while en_avmm_ctrl is low
    input  logic [7:0]                    dac_data_in,
    input  logic                          dac_data_in_valid_stb,
    output logic                          dac_data_in_updated_stb,

    output logic                          initdone,

    output logic                          spi_sclk,
    output logic                          spi_ssn,
    output logic                          spi_mosi
);

    logic       push;
    dac_frame_t push_frame;
    logic       pop;
    logic       pop_valid;
    dac_frame_t pop_frame;
    logic       frame_done;     // also returns a credit

    assign dac_data_in_updated_stb = frame_done;

    dac_reg_map u_reg_map (
        .clk_ifc               (clk_ifc),
        .set_default_on_reset  (set_default_on_reset),
        .en_avmm_ctrl          (en_avmm_ctrl),
        .address               (address),
        .write                 (write),
        .writedata             (writedata),
        .read                  (read),
        .readdata              (readdata),
        .readdatavalid         (readdatavalid),
        .writeresponsevalid    (writeresponsevalid),
        .response              (response),
        .dac_data_in           (dac_data_in),
        .dac_data_in_valid_stb (dac_data_in_valid_stb),
        .frame_done            (frame_done),
        .push                  (push),
        .push_frame            (push_frame),
        .initdone              (initdone)
    );

    dac_frame_fifo #(
        .payload_t (dac_frame_t)
    ) u_frame_fifo (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .push                 (push),
        .push_frame           (push_frame),
        .pop                  (pop),
        .pop_valid            (pop_valid),
        .pop_frame            (pop_frame)
    );

    dac_spi_shifter u_spi_shifter (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .pop_valid            (pop_valid),
        .pop_frame            (pop_frame),
        .pop                  (pop),
        .spi_sclk             (spi_sclk),
        .spi_ssn              (spi_ssn),
        .spi_mosi             (spi_mosi),
        .frame_done           (frame_done)
    );

endmodule

// ==== dac_regs/dac_reg_map.sv ====
// register map of the AD5601 controller
// decodes host bus accesses and pushes SPI frames under credit flow control
`timescale 1ns/1ps
`include "dac_consts.svh"

module dac_reg_map
    import dac_pkg::*;
(
    input  logic                   clk_ifc,
    input  logic                   set_default_on_reset,
    input  logic                   en_avmm_ctrl,
    input  logic [`DAC_ADDR_W-1:0] address,
    input  logic                   write,
    input  logic [`DAC_DATA_W-1:0] writedata,
    input  logic                   read,
    output logic [`DAC_DATA_W-1:0] readdata,
    output logic                   readdatavalid,
    output logic                   writeresponsevalid,
    output dac_resp_t              response,
    input  logic [7:0]             dac_data_in,
    input  logic                   dac_data_in_valid_stb,
    input  logic                   frame_done,
    output logic                   push,
    output dac_frame_t             push_frame,
    output logic                   initdone
);

    localparam int CREDIT_W = $clog2(`DAC_FIFO_DEPTH + 1);

    logic [`DAC_DATA_W-1:0] dac_reg;
    logic                   en_ctrl_q;      // registered copy of the pin
    logic [CREDIT_W-1:0]    credits;
    logic                   pending;        // newest frame waiting for a credit
    dac_frame_t             pend_frame;

    logic                   wr_dac;
    logic                   stb_dac;
    logic                   trigger;
    logic                   have_frame;
    logic                   credit_ok;
    logic                   take;
    dac_frame_t             new_frame;
    dac_frame_t             next_frame;
    logic [`DAC_DATA_W-1:0] rd_mux;

    ////////////////////////////////////////
    // frame source selection

    assign wr_dac  = write && (address == `DAC_ADDR_DAC_REG) && en_ctrl_q;
    assign stb_dac = dac_data_in_valid_stb && !en_ctrl_q;
    assign trigger = wr_dac || stb_dac;

    always_comb begin
        new_frame = dac_frame_t'(dac_reg[15:0]);
        if (wr_dac) begin
            new_frame = dac_frame_t'(writedata[15:0]);
        end else begin
            new_frame.code = dac_data_in;   // strobe only replaces the code bits
        end
    end

    // a fresh trigger always replaces an older held frame
    assign next_frame = trigger ? new_frame : pend_frame;
    assign have_frame = trigger || pending;
    assign credit_ok  = (credits != '0) || frame_done;   // returning credit usable at once
    assign take       = have_frame && credit_ok;

    ////////////////////////////////////////
    // control state

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            en_ctrl_q          <= 1'b0;
            dac_reg            <= `DAC_DATA_W'(`DAC_DEFAULT);
            credits            <= CREDIT_W'(`DAC_FIFO_DEPTH);
            pending            <= 1'b1;     // default frame goes out first
            pend_frame         <= dac_frame_t'(`DAC_DEFAULT);
            push               <= 1'b0;
            initdone           <= 1'b0;
            readdatavalid      <= 1'b0;
            writeresponsevalid <= 1'b0;
        end else begin
            en_ctrl_q          <= en_avmm_ctrl;
            readdatavalid      <= read;
            writeresponsevalid <= write;

            if (wr_dac) begin
                dac_reg <= writedata;
            end else if (stb_dac) begin
                dac_reg[13:6] <= dac_data_in;
            end

            credits    <= credits + CREDIT_W'(frame_done) - CREDIT_W'(take);
            push       <= take;
            pending    <= have_frame && !credit_ok;
            pend_frame <= next_frame;

            if (frame_done) begin
                initdone <= 1'b1;   // first completion is the default frame
            end
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (take) begin
            push_frame <= next_frame;
        end
    end

    ////////////////////////////////////////
    // read path

    always_comb begin
        case (address)
            `DAC_ADDR_VERSION: rd_mux = `DAC_VERSION_ID;
            `DAC_ADDR_STATE:   rd_mux = `DAC_DATA_W'(1);    // device up
            `DAC_ADDR_DAC_REG: rd_mux = dac_reg;
            `DAC_ADDR_EN_CTRL: rd_mux = `DAC_DATA_W'(en_ctrl_q);
            default:           rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_ifc) begin
        if (read) begin
            readdata <= rd_mux;
        end
        if (read || write) begin
            response <= (address >= `DAC_NUM_REGS) ? DAC_RESP_SLVERR : DAC_RESP_OKAY;
        end
    end

endmodule

// ==== spi/dac_spi_shifter.sv ====
// serializes one AD5601 frame per queue entry, MSB first
// SCLK idles high and data is stable on the falling edge
`timescale 1ns/1ps
`include "dac_consts.svh"

module dac_spi_shifter
    import dac_pkg::*;
(
    input  logic       clk_ifc,
    input  logic       set_default_on_reset,
    input  logic       pop_valid,
    input  dac_frame_t pop_frame,
    output logic       pop,
    output logic       spi_sclk,
    output logic       spi_ssn,
    output logic       spi_mosi,
    output logic       frame_done
);

    localparam int FRAME_BITS = $bits(dac_frame_t);
    localparam int BIT_W      = $clog2(FRAME_BITS + 1);
    localparam int DIV_W      = (`DAC_SCLK_DIV > 1) ? $clog2(`DAC_SCLK_DIV) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,   // ssn low, first bit on mosi before the first falling edge
        ST_SHIFT
    } state_t;

    state_t                state;
    logic [DIV_W-1:0]      div_cnt;
    logic [BIT_W-1:0]      bit_cnt;     // rising edges seen so far
    logic [FRAME_BITS-1:0] shreg;
    logic                  half_end;

    assign pop      = (state == ST_IDLE) && pop_valid;
    assign half_end = (div_cnt == DIV_W'(`DAC_SCLK_DIV - 1));
    assign spi_mosi = shreg[FRAME_BITS-1];

    ////////////////////////////////////////
    // sclk / ssn sequencing

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            state      <= ST_IDLE;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            spi_sclk   <= 1'b1;
            spi_ssn    <= 1'b1;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (pop) begin
                        state   <= ST_SETUP;
                        spi_ssn <= 1'b0;
                        bit_cnt <= '0;
                        div_cnt <= '0;
                    end
                end
                ST_SETUP: begin
                    state    <= ST_SHIFT;
                    spi_sclk <= 1'b0;       // first falling edge
                end
                ST_SHIFT: begin
                    div_cnt <= half_end ? '0 : div_cnt + 1'b1;
                    if (half_end) begin
                        if (!spi_sclk) begin
                            spi_sclk <= 1'b1;
                            bit_cnt  <= bit_cnt + 1'b1;
                        end else if (bit_cnt == BIT_W'(FRAME_BITS)) begin
                            // last high half done, close the frame
                            state      <= ST_IDLE;
                            spi_ssn    <= 1'b1;
                            frame_done <= 1'b1;
                        end else begin
                            spi_sclk <= 1'b0;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // next bit appears together with the rising edge
    always_ff @(posedge clk_ifc) begin
        if (pop) begin
            shreg <= pop_frame;
        end else if (state == ST_SHIFT && half_end && !spi_sclk) begin
            shreg <= shreg << 1;
        end
    end

endmodule

// ==== hdl/dac_frame_fifo.sv ====
// small circular queue between a producer and a consumer
// no full flag, the producer's credits keep it from overflowing
`timescale 1ns/1ps
`include "dac_consts.svh"

module dac_frame_fifo #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     clk_ifc,
    input  logic     set_default_on_reset,
    input  logic     push,
    input  payload_t push_frame,
    input  logic     pop,
    output logic     pop_valid,
    output payload_t pop_frame
);

    localparam int DEPTH = `DAC_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pop_valid = (count != '0);
    assign pop_frame = mem[rd_ptr];     // head entry, valid with pop_valid

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (push) begin
            mem[wr_ptr] <= push_frame;
        end
    end

endmodule

// ==== common/dac_pkg.sv ====
// shared types for the AD5601 controller
// imported by the register map, the top level and the SPI shifter
package dac_pkg;

    ////////////////////////////////////////
    // spi frame

    // AD5601 input shift register, sent MSB first
    typedef struct packed {
        logic [1:0] mode;   // power-down mode, 00 is normal operation
        logic [7:0] code;   // dac code
        logic [5:0] pad;    // don't care for the part
    } dac_frame_t;

    ////////////////////////////////////////
    // bus response

    // same encoding as the Avalon-MM response field
    typedef enum logic [1:0] {
        DAC_RESP_OKAY   = 2'b00,
        DAC_RESP_SLVERR = 2'b10
    } dac_resp_t;

endpackage

// ==== common/dac_consts.svh ====
// constants for the AD5601 controller
// include wherever register addresses, widths or SPI timing are needed
`ifndef DAC_CONSTS_SVH
`define DAC_CONSTS_SVH

// register word addresses
`define DAC_ADDR_VERSION    0
`define DAC_ADDR_STATE      1
`define DAC_ADDR_DAC_REG    2
`define DAC_ADDR_EN_CTRL    3
`define DAC_NUM_REGS        4

// module version in the upper half, id in the lower half
`define DAC_VERSION_ID      32'h0001_0056

// frame sent after reset, normal mode at mid-scale
`define DAC_DEFAULT         16'h2000

// host bus
`define DAC_DATA_W          32
`define DAC_ADDR_W          4

// frame queue size, also the producer's initial credits
`define DAC_FIFO_DEPTH      2

// clock cycles per SCLK half period
`define DAC_SCLK_DIV        2

`endif
